//--- test/exMemTestdata.txt
# test pc rs1 rs2 imm funct3 aluOp aluSrcImm rd branch jump jalr memRead memWrite memToReg regWrite
# then expected wbRegWrite wbRd wbData redirect redirectPc; test in decimal, all else in hex
01 00000000 00000005 00000007 00000000 0 0 0 01 0 0 0 0 0 0 1 1 01 0000000c 0 00000000
02 00000000 00000003 00000000 00000005 0 1 1 02 0 0 0 0 0 0 1 1 02 fffffffe 0 00000000
03 00000000 f0f0f0f0 0ff00ff0 00000000 0 2 0 03 0 0 0 0 0 0 1 1 03 00f000f0 0 00000000
04 00000000 12340000 00000000 00005678 0 3 1 04 0 0 0 0 0 0 1 1 04 12345678 0 00000000
05 00000000 ffff0000 0f0f0f0f 00000000 0 4 0 05 0 0 0 0 0 0 1 1 05 f0f00f0f 0 00000000
06 00000000 00000001 00000000 00000024 0 5 1 06 0 0 0 0 0 0 1 1 06 00000010 0 00000000
07 00000000 80000000 00000004 00000000 0 7 0 07 0 0 0 0 0 0 1 1 07 f8000000 0 00000000
08 00000000 80000000 00000004 00000000 0 6 0 08 0 0 0 0 0 0 1 1 08 08000000 0 00000000
09 00000000 ffffffff 00000001 00000000 0 8 0 09 0 0 0 0 0 0 1 1 09 00000001 0 00000000
10 00000000 ffffffff 00000001 00000000 0 9 0 0a 0 0 0 0 0 0 1 1 0a 00000000 0 00000000
11 00000000 00000001 00000001 00000000 0 0 0 00 0 0 0 0 0 0 1 0 00 00000000 0 00000000
12 00000100 00000005 00000005 00000020 0 0 0 00 1 0 0 0 0 0 0 0 00 00000000 1 00000120
13 00000104 00000001 00000002 00000000 0 0 0 0b 0 0 0 0 0 0 1 0 00 00000000 0 00000000
14 00000200 00000005 00000005 00000040 1 0 0 00 1 0 0 0 0 0 0 0 00 00000000 0 00000000
15 00000204 00000001 00000002 00000000 0 0 0 0c 0 0 0 0 0 0 1 1 0c 00000003 0 00000000
16 00000300 ffffffff 00000001 fffffff0 4 0 0 00 1 0 0 0 0 0 0 0 00 00000000 1 000002f0
17 00000304 00000080 deadbeef 00000000 2 0 1 00 0 0 0 0 1 0 0 0 00 00000000 0 00000000
18 00000400 00000000 00000000 00000100 0 0 0 01 0 1 0 0 0 0 1 1 01 00000404 1 00000500
19 00000404 00000001 00000000 00000000 0 0 0 0d 0 0 0 0 0 0 1 0 00 00000000 0 00000000
20 00000600 00001001 00000000 00000004 0 0 1 02 0 0 1 0 0 0 1 1 02 00000604 1 00001004
21 00000604 00000001 00000000 00000000 0 0 0 0e 0 0 0 0 0 0 1 0 00 00000000 0 00000000
22 00000000 00000040 000000a5 00000001 0 0 1 00 0 0 0 0 1 0 0 0 00 00000000 0 00000000
23 00000000 00000040 00008123 00000002 1 0 1 00 0 0 0 0 1 0 0 0 00 00000000 0 00000000
24 00000000 00000040 00000000 00000000 2 0 1 03 0 0 0 1 0 1 1 1 03 8123a500 0 00000000
25 00000000 00000040 00000000 00000001 0 0 1 04 0 0 0 1 0 1 1 1 04 ffffffa5 0 00000000
26 00000000 00000040 00000000 00000001 4 0 1 05 0 0 0 1 0 1 1 1 05 000000a5 0 00000000
27 00000000 00000040 00000000 00000002 1 0 1 06 0 0 0 1 0 1 1 1 06 ffff8123 0 00000000
28 00000000 00000040 00000000 00000002 5 0 1 07 0 0 0 1 0 1 1 1 07 00008123 0 00000000
29 00000000 00000040 cafef00d 00000004 2 0 1 00 0 0 0 0 1 0 0 0 00 00000000 0 00000000
30 00000000 00000040 00000000 00000004 2 0 1 08 0 0 0 1 0 1 1 1 08 cafef00d 0 00000000
31 00000000 00000080 00000000 00000000 2 0 1 09 0 0 0 1 0 1 1 1 09 00000000 0 00000000

//--- flist.f
rtl/riscvPkg.sv
rtl/executeUnit.sv
rtl/exMemReg.sv
rtl/memStage.sv
rtl/dataRam.sv
rtl/exMemTop.sv
test/exMemTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exMemTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/exMemTb.sv
`timescale 1ns/100ps
`default_nettype none

module exMemTb;

    import riscvPkg::*;

    localparam int    CLK_PERIOD    = 100;
    localparam int    RESET_CYCLES  = 4;
    localparam int    RESET_TIMEOUT = 20;
    localparam int    MAX_LINES     = 200;
    localparam int    NUM_FIELDS    = 21;
    localparam string DATA_FILE     = "test/exMemTestdata.txt";

    logic                clk = 1'b0;
    logic                reset_i;
    logic [XLEN-1:0]     pc_i, rs1Val_i, rs2Val_i, imm_i;
    logic [2:0]          funct3_i;
    logic [ALUOP_W-1:0]  aluOp_i;
    logic                aluSrcImm_i;
    logic [4:0]          rd_i;
    logic                branch_i, jump_i, jalr_i;
    logic                memRead_i, memWrite_i, memToReg_i, regWrite_i;
    logic                wbRegWrite_o;
    logic [4:0]          wbRd_o;
    logic [XLEN-1:0]     wbData_o;
    logic                redirect_o;
    logic [XLEN-1:0]     redirectPc_o;

    // One parsed line, then the expectations of the vector in flight
    logic [31:0] fields [NUM_FIELDS];
    logic [31:0] pendRegWrite, pendRd, pendData, pendRedirect, pendTarget;
    string       vectors [$];
    int          testNum;
    int          testErrors;
    int          passCount;
    int          failCount;
    bit          setupOk = 1'b1;

    exMemTop u_exMemTop (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
    end

    // ------------------------------------------------------------------------
    // Vector handling
    // ------------------------------------------------------------------------
    function automatic int parseVector(input string text);
        return $sscanf(text,
            "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
            fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
            fields[12], fields[13], fields[14], fields[15], fields[16], fields[17],
            fields[18], fields[19], fields[20]);
    endfunction

    task automatic readVectors();
        int    fd;
        int    code;
        int    lineCount;
        int    badLines;
        string text;
        lineCount = 0;
        badLines  = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && lineCount < MAX_LINES) begin
                code = $fgets(text, fd);
                lineCount++;
                // Skip blank lines and column notes
                if (code > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    if (parseVector(text) == NUM_FIELDS) begin
                        vectors.push_back(text);
                    end else begin
                        badLines++;
                    end
                end
            end
            if (!$feof(fd)) begin
                badLines++;
            end
            $fclose(fd);
        end
        if (fd == 0 || badLines != 0 || vectors.size() == 0) begin
            $display("test data file missing or truncated");
            setupOk = 1'b0;
        end
    endtask

    task automatic driveFields();
        pc_i        <= fields[1];
        rs1Val_i    <= fields[2];
        rs2Val_i    <= fields[3];
        imm_i       <= fields[4];
        funct3_i    <= fields[5][2:0];
        aluOp_i     <= fields[6][ALUOP_W-1:0];
        aluSrcImm_i <= fields[7][0];
        rd_i        <= fields[8][4:0];
        branch_i    <= fields[9][0];
        jump_i      <= fields[10][0];
        jalr_i      <= fields[11][0];
        memRead_i   <= fields[12][0];
        memWrite_i  <= fields[13][0];
        memToReg_i  <= fields[14][0];
        regWrite_i  <= fields[15][0];
    endtask

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            $display("** Error at %0t ns: test %0d %s is %h, expected %h",
                     $time, testNum, name, got, want);
            testErrors++;
        end
    endtask

    task automatic reportTest();
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d passed", testNum);
        end else begin
            failCount++;
            $display("test %0d failed with %0d mismatches", testNum, testErrors);
        end
    endtask

    task automatic checkPending();
        testErrors = 0;
        compareField("wbRegWrite_o", 32'(wbRegWrite_o), pendRegWrite);
        compareField("redirect_o", 32'(redirect_o), pendRedirect);
        // Data and target only mean something when their strobe is expected
        if (pendRegWrite[0]) begin
            compareField("wbRd_o", 32'(wbRd_o), pendRd);
            compareField("wbData_o", wbData_o, pendData);
        end
        if (pendRedirect[0]) begin
            compareField("redirectPc_o", redirectPc_o, pendTarget);
        end
        reportTest();
    endtask

    task automatic waitForReset();
        int waitCycles;
        waitCycles = 0;
        while (reset_i !== 1'b0 && waitCycles < RESET_TIMEOUT) begin
            @(negedge clk);
            waitCycles++;
        end
        if (reset_i !== 1'b0) begin
            $display("Timed out waiting for reset to be released");
            setupOk = 1'b0;
        end
    endtask

    // Vector i is driven while vector i-1 sits in the MEM stage
    task automatic runVectors();
        for (int i = 0; i <= vectors.size(); i++) begin
            @(posedge clk);
            if (i < vectors.size()) begin
                void'(parseVector(vectors[i]));
            end else begin
                fields = '{default: '0};
            end
            driveFields();
            @(negedge clk);
            if (i > 0) begin
                checkPending();
            end
            testNum      = fields[0];
            pendRegWrite = fields[16];
            pendRd       = fields[17];
            pendData     = fields[18];
            pendRedirect = fields[19];
            pendTarget   = fields[20];
        end
    endtask

    initial begin
        // A jump writing x1 is held through reset, only reset keeps the outputs idle
        fields     = '{default: '0};
        fields[8]  = 32'd1;
        fields[10] = 32'd1;
        fields[15] = 32'd1;
        driveFields();
        readVectors();
        if (setupOk) begin
            waitForReset();
        end
        if (setupOk) begin
            testNum    = 0;
            testErrors = 0;
            compareField("wbRegWrite_o", 32'(wbRegWrite_o), 32'd0);
            compareField("redirect_o", 32'(redirect_o), 32'd0);
            reportTest();
            // Idle slot absorbs the flush from the jump captured after reset
            @(posedge clk);
            fields = '{default: '0};
            driveFields();
            runVectors();
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 passCount + failCount, passCount, failCount);
        if (setupOk && failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/exMemTop.sv
`timescale 1ns/100ps
`default_nettype none

module exMemTop (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [riscvPkg::XLEN-1:0]    pc_i,
    input  logic [riscvPkg::XLEN-1:0]    rs1Val_i,
    input  logic [riscvPkg::XLEN-1:0]    rs2Val_i,
    input  logic [riscvPkg::XLEN-1:0]    imm_i,
    input  logic [2:0]                   funct3_i,
    input  logic [riscvPkg::ALUOP_W-1:0] aluOp_i,
    input  logic                         aluSrcImm_i,
    input  logic [4:0]                   rd_i,
    input  logic                         branch_i,
    input  logic                         jump_i,
    input  logic                         jalr_i,
    input  logic                         memRead_i,
    input  logic                         memWrite_i,
    input  logic                         memToReg_i,
    input  logic                         regWrite_i,
    output logic                         wbRegWrite_o,
    output logic [4:0]                   wbRd_o,
    output logic [riscvPkg::XLEN-1:0]    wbData_o,
    output logic                         redirect_o,
    output logic [riscvPkg::XLEN-1:0]    redirectPc_o
);

    import riscvPkg::*;

    // EX side
    logic [XLEN-1:0] exAluResult, exTarget, exPc4;
    logic            exCondMet;

    // MEM side
    logic [XLEN-1:0] memAluResult, memTarget, memPc4, memRs2Val;
    logic            memCondMet, memBranch, memJump, memJalr;
    logic            memMemWrite, memMemToReg, memRegWrite;
    logic [4:0]      memRd;
    logic [2:0]      memFunct3;

    // Data memory port
    logic [DMEM_AW-1:0] ramAddr;
    logic [3:0]         ramWe;
    logic [XLEN-1:0]    ramWdata, ramRdata;

    executeUnit u_executeUnit (
        .pc_i, .rs1Val_i, .rs2Val_i, .imm_i, .funct3_i, .aluOp_i, .aluSrcImm_i, .jalr_i,
        .aluResult_o(exAluResult), .target_o(exTarget), .pc4_o(exPc4),
        .condMet_o(exCondMet)
    );

    exMemReg u_exMemReg (
        .clk, .reset_i, .flush_i(redirect_o),
        .aluResult_i(exAluResult), .target_i(exTarget), .pc4_i(exPc4), .rs2Val_i,
        .condMet_i(exCondMet), .branch_i, .jump_i, .jalr_i, .memRead_i, .memWrite_i,
        .memToReg_i, .regWrite_i, .rd_i, .funct3_i,
        .aluResult_o(memAluResult), .target_o(memTarget), .pc4_o(memPc4),
        .rs2Val_o(memRs2Val), .condMet_o(memCondMet), .branch_o(memBranch),
        .jump_o(memJump), .jalr_o(memJalr), .memRead_o(),
        .memWrite_o(memMemWrite), .memToReg_o(memMemToReg),
        .regWrite_o(memRegWrite), .rd_o(memRd), .funct3_o(memFunct3)
    );

    memStage u_memStage (
        .aluResult_i(memAluResult), .target_i(memTarget), .pc4_i(memPc4),
        .rs2Val_i(memRs2Val), .ramRdata_i(ramRdata), .condMet_i(memCondMet),
        .branch_i(memBranch), .jump_i(memJump), .jalr_i(memJalr),
        .memWrite_i(memMemWrite), .memToReg_i(memMemToReg),
        .regWrite_i(memRegWrite), .rd_i(memRd), .funct3_i(memFunct3),
        .ramAddr_o(ramAddr), .ramWe_o(ramWe), .ramWdata_o(ramWdata),
        .redirect_o, .redirectPc_o, .wbRegWrite_o, .wbRd_o, .wbData_o
    );

    dataRam u_dataRam (
        .clk, .addr_i(ramAddr), .we_i(ramWe), .wdata_i(ramWdata), .rdata_o(ramRdata)
    );

endmodule

`default_nettype wire

//--- rtl/dataRam.sv
`timescale 1ns/100ps
`default_nettype none

module dataRam (
    input  logic                         clk,
    input  logic [riscvPkg::DMEM_AW-1:0] addr_i,
    input  logic [3:0]                   we_i,
    input  logic [riscvPkg::XLEN-1:0]    wdata_i,
    output logic [riscvPkg::XLEN-1:0]    rdata_o
);

    import riscvPkg::*;

    localparam int DEPTH = 2 ** DMEM_AW;

    logic [XLEN-1:0] mem [DEPTH];

    // Simulation starts from a cleared memory
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // One enable per byte lane
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we_i[lane]) begin
                mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
            end
        end
    end

    // Read path is combinational
    assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire

//--- rtl/memStage.sv
`timescale 1ns/100ps
`default_nettype none

module memStage (
    input  logic [riscvPkg::XLEN-1:0]    aluResult_i,
    input  logic [riscvPkg::XLEN-1:0]    target_i,
    input  logic [riscvPkg::XLEN-1:0]    pc4_i,
    input  logic [riscvPkg::XLEN-1:0]    rs2Val_i,
    input  logic [riscvPkg::XLEN-1:0]    ramRdata_i,
    input  logic                         condMet_i,
    input  logic                         branch_i,
    input  logic                         jump_i,
    input  logic                         jalr_i,
    input  logic                         memWrite_i,
    input  logic                         memToReg_i,
    input  logic                         regWrite_i,
    input  logic [4:0]                   rd_i,
    input  logic [2:0]                   funct3_i,
    output logic [riscvPkg::DMEM_AW-1:0] ramAddr_o,
    output logic [3:0]                   ramWe_o,
    output logic [riscvPkg::XLEN-1:0]    ramWdata_o,
    output logic                         redirect_o,
    output logic [riscvPkg::XLEN-1:0]    redirectPc_o,
    output logic                         wbRegWrite_o,
    output logic [4:0]                   wbRd_o,
    output logic [riscvPkg::XLEN-1:0]    wbData_o
);

    import riscvPkg::*;

    logic [1:0]      byteSel;
    logic [3:0]      storeMask;
    logic [7:0]      loadByte;
    logic [15:0]     loadHalf;
    logic [XLEN-1:0] loadData;

    // Branch resolution
    assign redirect_o   = (branch_i && condMet_i) || jump_i || jalr_i;
    assign redirectPc_o = target_i;

    // ------------------------------------------------------------------------
    // Store steering
    // ------------------------------------------------------------------------
    assign byteSel   = aluResult_i[1:0];
    assign ramAddr_o = aluResult_i[DMEM_AW+1:2];

    always_comb begin
        case (funct3_i)
            F3_B: begin
                ramWdata_o = {4{rs2Val_i[7:0]}};
                storeMask  = 4'b0001 << byteSel;
            end
            F3_H: begin
                ramWdata_o = {2{rs2Val_i[15:0]}};
                storeMask  = byteSel[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ramWdata_o = rs2Val_i;
                storeMask  = 4'b1111;
            end
        endcase
    end

    assign ramWe_o = memWrite_i ? storeMask : 4'b0000;

    // ------------------------------------------------------------------------
    // Load lane select and extension
    // ------------------------------------------------------------------------
    assign loadByte = ramRdata_i[8*byteSel +: 8];
    assign loadHalf = byteSel[1] ? ramRdata_i[31:16] : ramRdata_i[15:0];

    always_comb begin
        case (funct3_i)
            F3_B:    loadData = {{(XLEN-8){loadByte[7]}}, loadByte};
            F3_BU:   loadData = {{(XLEN-8){1'b0}}, loadByte};
            F3_H:    loadData = {{(XLEN-16){loadHalf[15]}}, loadHalf};
            F3_HU:   loadData = {{(XLEN-16){1'b0}}, loadHalf};
            default: loadData = ramRdata_i;
        endcase
    end

    // Writeback, x0 never written
    assign wbRegWrite_o = regWrite_i && (rd_i != 5'd0);
    assign wbRd_o       = rd_i;
    assign wbData_o     = (jump_i || jalr_i) ? pc4_i :
                          memToReg_i         ? loadData : aluResult_i;

    // Target from the execute stage must be word aligned when taken
    always_comb begin
        if (redirect_o) begin
            redirectAligned: assert final (redirectPc_o[1:0] == 2'b00);
        end
    end

endmodule

`default_nettype wire

//--- rtl/exMemReg.sv
`timescale 1ns/100ps
`default_nettype none

module exMemReg (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      flush_i,
    input  logic [riscvPkg::XLEN-1:0] aluResult_i,
    input  logic [riscvPkg::XLEN-1:0] target_i,
    input  logic [riscvPkg::XLEN-1:0] pc4_i,
    input  logic [riscvPkg::XLEN-1:0] rs2Val_i,
    input  logic                      condMet_i,
    input  logic                      branch_i,
    input  logic                      jump_i,
    input  logic                      jalr_i,
    input  logic                      memRead_i,
    input  logic                      memWrite_i,
    input  logic                      memToReg_i,
    input  logic                      regWrite_i,
    input  logic [4:0]                rd_i,
    input  logic [2:0]                funct3_i,
    output logic [riscvPkg::XLEN-1:0] aluResult_o,
    output logic [riscvPkg::XLEN-1:0] target_o,
    output logic [riscvPkg::XLEN-1:0] pc4_o,
    output logic [riscvPkg::XLEN-1:0] rs2Val_o,
    output logic                      condMet_o,
    output logic                      branch_o,
    output logic                      jump_o,
    output logic                      jalr_o,
    output logic                      memRead_o,
    output logic                      memWrite_o,
    output logic                      memToReg_o,
    output logic                      regWrite_o,
    output logic [4:0]                rd_o,
    output logic [2:0]                funct3_o
);

    // A flushed slot becomes an all-zero bubble
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            aluResult_o <= '0;
            target_o    <= '0;
            pc4_o       <= '0;
            rs2Val_o    <= '0;
            condMet_o   <= 1'b0;
            branch_o    <= 1'b0;
            jump_o      <= 1'b0;
            jalr_o      <= 1'b0;
            memRead_o   <= 1'b0;
            memWrite_o  <= 1'b0;
            memToReg_o  <= 1'b0;
            regWrite_o  <= 1'b0;
            rd_o        <= '0;
            funct3_o    <= '0;
        end else begin
            aluResult_o <= aluResult_i;
            target_o    <= target_i;
            pc4_o       <= pc4_i;
            rs2Val_o    <= rs2Val_i;
            condMet_o   <= condMet_i;
            branch_o    <= branch_i;
            jump_o      <= jump_i;
            jalr_o      <= jalr_i;
            memRead_o   <= memRead_i;
            memWrite_o  <= memWrite_i;
            memToReg_o  <= memToReg_i;
            regWrite_o  <= regWrite_i;
            rd_o        <= rd_i;
            funct3_o    <= funct3_i;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // Decode never marks one instruction as both load and store
    loadStoreExclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(memRead_i && memWrite_i));

endmodule

`default_nettype wire

//--- rtl/executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    input  logic [riscvPkg::XLEN-1:0]    pc_i,
    input  logic [riscvPkg::XLEN-1:0]    rs1Val_i,
    input  logic [riscvPkg::XLEN-1:0]    rs2Val_i,
    input  logic [riscvPkg::XLEN-1:0]    imm_i,
    input  logic [2:0]                   funct3_i,
    input  logic [riscvPkg::ALUOP_W-1:0] aluOp_i,
    input  logic                         aluSrcImm_i,
    input  logic                         jalr_i,
    output logic [riscvPkg::XLEN-1:0]    aluResult_o,
    output logic [riscvPkg::XLEN-1:0]    target_o,
    output logic [riscvPkg::XLEN-1:0]    pc4_o,
    output logic                         condMet_o
);

    import riscvPkg::*;

    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;
    logic            isEq;
    logic            isLt;
    logic            isLtu;
    logic [XLEN-1:0] jumpSum;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    assign opB   = aluSrcImm_i ? imm_i : rs2Val_i;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp_i)
            ALU_ADD:  aluResult_o = rs1Val_i + opB;
            ALU_SUB:  aluResult_o = rs1Val_i - opB;
            ALU_AND:  aluResult_o = rs1Val_i & opB;
            ALU_OR:   aluResult_o = rs1Val_i | opB;
            ALU_XOR:  aluResult_o = rs1Val_i ^ opB;
            ALU_SLL:  aluResult_o = rs1Val_i << shamt;
            ALU_SRL:  aluResult_o = rs1Val_i >> shamt;
            ALU_SRA:  aluResult_o = $signed(rs1Val_i) >>> shamt;
            ALU_SLT: begin
                aluResult_o = {{(XLEN-1){1'b0}}, $signed(rs1Val_i) < $signed(opB)};
            end
            ALU_SLTU: aluResult_o = {{(XLEN-1){1'b0}}, rs1Val_i < opB};
            default:  aluResult_o = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Branch compare, always rs1 against rs2
    // ------------------------------------------------------------------------
    assign isEq  = (rs1Val_i == rs2Val_i);
    assign isLt  = ($signed(rs1Val_i) < $signed(rs2Val_i));
    assign isLtu = (rs1Val_i < rs2Val_i);

    always_comb begin
        case (funct3_i)
            F3_BEQ:  condMet_o = isEq;
            F3_BNE:  condMet_o = !isEq;
            F3_BLT:  condMet_o = isLt;
            F3_BGE:  condMet_o = !isLt;
            F3_BLTU: condMet_o = isLtu;
            F3_BGEU: condMet_o = !isLtu;
            default: condMet_o = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------------
    // jalr adds to rs1 and drops the low bit
    assign jumpSum  = (jalr_i ? rs1Val_i : pc_i) + imm_i;
    assign target_o = {jumpSum[XLEN-1:1], jumpSum[0] & !jalr_i};

    // Link value for jal and jalr
    assign pc4_o = pc_i + XLEN'(4);

endmodule

`default_nettype wire

//--- rtl/riscvPkg.sv
`default_nettype none

package riscvPkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------
    localparam int XLEN    = 32;
    localparam int ALUOP_W = 4;

    // Data memory word address, 256 words
    localparam int DMEM_AW = 8;

    // ------------------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------------------
    localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALUOP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALUOP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALUOP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'd9;

    // ------------------------------------------------------------------------
    // funct3 encodings
    // ------------------------------------------------------------------------
    // Branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store sizes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage

`default_nettype wire
